// ==== include/tbCompare.svh ====
`ifndef TB_COMPARE_SVH
`define TB_COMPARE_SVH

  // Prints the mismatch and ends the run
  task automatic reportMismatch(input string name, input string actual, input string expected);
    $display("ERR %0t %s actual=%s expected=%s", $time, name, actual, expected);
    $display("Some tests failed");
    $fatal(1, "Mismatch on %s", name);
  endtask

  // Single control bit
  task automatic compareBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      reportMismatch(name, $sformatf("%b", actual), $sformatf("%b", expected));
    end
  endtask

  // Addresses and vectors
  task automatic compareWord(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      reportMismatch(name, $sformatf("%h", actual), $sformatf("%h", expected));
    end
  endtask

  // Banked mode printed by name
  task automatic compareMode(input string name, input excPkg::procModeT actual,
                             input excPkg::procModeT expected);
    if (actual !== expected) begin
      reportMismatch(name, actual.name(), expected.name());
    end
  endtask

`endif

// ==== verilog/excPkg.sv ====
`default_nettype none

package excPkg;

  // Winning exception source, one per vector
  // causeNone means no source is active this cycle
  typedef enum logic [2:0] {
    causeNone          = 3'd0,
    causeReset         = 3'd1,
    causeUndef         = 3'd2,
    causeSwi           = 3'd3,
    causePrefetchAbort = 3'd4,
    causeDataAbort     = 3'd5,
    causeIrq           = 3'd6,
    causeFiq           = 3'd7
  } excCauseT;

  // Which PC goes into the link register
  // Normal is PCD+8 and means nothing is saved
  typedef enum logic [1:0] {
    pcSelNormal = 2'b00,
    pcSelPlus0  = 2'b01,
    pcSelPlus4  = 2'b10
  } pcSelT;

  // Processor mode to bank into on exception entry
  typedef enum logic [2:0] {
    modeSvc = 3'd0,
    modeUnd = 3'd1,
    modeAbt = 3'd2,
    modeIrq = 3'd3,
    modeFiq = 3'd4
  } procModeT;

  // Exception vector table
  // 0x14 is the reserved slot and is never selected
  localparam logic [31:0] vecReset         = 32'h0000_0000;
  localparam logic [31:0] vecUndef         = 32'h0000_0004;
  localparam logic [31:0] vecSwi           = 32'h0000_0008;
  localparam logic [31:0] vecPrefetchAbort = 32'h0000_000C;
  localparam logic [31:0] vecDataAbort     = 32'h0000_0010;
  localparam logic [31:0] vecIrq           = 32'h0000_0018;
  localparam logic [31:0] vecFiq           = 32'h0000_001C;

  // Offsets added to PCD when forming the link address
  localparam logic [31:0] linkOffsetPlus0  = 32'd0;
  localparam logic [31:0] linkOffsetPlus4  = 32'd4;
  localparam logic [31:0] linkOffsetNormal = 32'd8;

endpackage

`default_nettype wire

// ==== verilog/exceptionHandler.sv ====
`timescale 1ns/1ps
`default_nettype none

module exceptionHandler import excPkg::*; (
  input  logic  clk,
  input  logic  arstN,
  input  logic  undefinedInstrE,
  input  logic  swiE,
  input  logic  prefetchAbortE,
  input  logic  dataAbort,
  input  logic  irq,
  input  logic  fiq,
  input  logic  irqEnabled,
  input  logic  fiqEnabled,
  input  logic  pipelineClearD,
  input  logic  pipelineClearM,
  output logic  undefinedInstrM,
  output logic  swiM,
  output logic  prefetchAbortM,
  output logic  dataAbortCycle2,
  output logic  irqAssert,
  output logic  fiqAssert,
  output logic  pipelineClearF,
  output logic  flushD,
  output logic  flushE,
  output logic  flushM,
  output logic  flushW,
  output logic  stallD,
  output logic  resetMicrop,
  output logic  exceptionSavePc,
  output pcSelT pcInSelect
);

  logic irqEnabledSync;
  logic fiqEnabledSync;
  logic stageExcE;

  // Any of the three exceptions caught in E
  assign stageExcE = prefetchAbortE | undefinedInstrE | swiE;

  // M-stage copies of the exception flags
  // dataAbortCycle2 is the abort the rest of the core sees
  // The CPSR enables change mid-cycle so they are lined up with the edge here
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      undefinedInstrM <= 1'b0;
      swiM            <= 1'b0;
      prefetchAbortM  <= 1'b0;
      dataAbortCycle2 <= 1'b0;
      irqEnabledSync  <= 1'b0;
      fiqEnabledSync  <= 1'b0;
    end else begin
      undefinedInstrM <= undefinedInstrE;
      swiM            <= swiE;
      prefetchAbortM  <= prefetchAbortE;
      dataAbortCycle2 <= dataAbort;
      irqEnabledSync  <= irqEnabled;
      fiqEnabledSync  <= fiqEnabled;
    end
  end

  // Priority chain for flush, stall and drain
  always_comb begin
    irqAssert      = 1'b0;
    fiqAssert      = 1'b0;
    pipelineClearF = 1'b0;
    flushD         = 1'b0;
    flushE         = 1'b0;
    flushM         = 1'b0;
    flushW         = 1'b0;
    stallD         = 1'b0;
    if (dataAbort || dataAbortCycle2) begin
      // Caught in M so the first cycle stalls D and kills E
      // Second cycle only flushes and the PC is saved then
      flushD = 1'b1;
      flushE = dataAbort;
      flushM = 1'b1;
      flushW = 1'b1;
      stallD = dataAbort;
    end else if (stageExcE) begin
      // Let the older instruction in M finish so flags are right
      flushD = 1'b1;
      flushM = 1'b1;
    end else if ((fiq && fiqEnabledSync) || (irq && irqEnabledSync)) begin
      // Drain token rides the zero instruction from F to M
      // Once it reaches M every real instruction has retired
      pipelineClearF = ~pipelineClearM;
      fiqAssert      = pipelineClearM & fiq & fiqEnabledSync;
      irqAssert      = pipelineClearM & ~(fiq & fiqEnabledSync);
      flushD         = pipelineClearM;
      flushE         = pipelineClearD & ~pipelineClearM;
      stallD         = pipelineClearD & ~pipelineClearM;
    end
  end

  // Abort the micro-op sequence on the first abort cycle
  assign resetMicrop = dataAbort;

  // Reset also counts as a save so the reset vector gets fetched
  assign exceptionSavePc = ~arstN | dataAbortCycle2 | stageExcE | irqAssert | fiqAssert;

  // Offset of the PC that goes to the link register
  always_comb begin
    if (irqAssert || fiqAssert) begin
      pcInSelect = pcSelPlus4;
    end else if (stageExcE || dataAbortCycle2) begin
      pcInSelect = pcSelPlus0;
    end else begin
      pcInSelect = pcSelNormal;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exceptionVectorAddress.sv ====
`timescale 1ns/1ps
`default_nettype none

module exceptionVectorAddress import excPkg::*; (
  input  logic        arstN,
  input  logic        dataAbortCycle2,
  input  logic        fiqAssert,
  input  logic        irqAssert,
  input  logic        prefetchAbortE,
  input  logic        undefinedInstrE,
  input  logic        swiE,
  output logic [31:0] vectorPcNextF,
  output excCauseT    cause
);

  // Highest active source wins
  // Same ranking as the handler, interrupts last
  always_comb begin
    if (!arstN) begin
      cause         = causeReset;
      vectorPcNextF = vecReset;
    end else if (dataAbortCycle2) begin
      cause         = causeDataAbort;
      vectorPcNextF = vecDataAbort;
    end else if (prefetchAbortE) begin
      cause         = causePrefetchAbort;
      vectorPcNextF = vecPrefetchAbort;
    end else if (undefinedInstrE) begin
      cause         = causeUndef;
      vectorPcNextF = vecUndef;
    end else if (swiE) begin
      cause         = causeSwi;
      vectorPcNextF = vecSwi;
    end else if (fiqAssert) begin
      cause         = causeFiq;
      vectorPcNextF = vecFiq;
    end else if (irqAssert) begin
      cause         = causeIrq;
      vectorPcNextF = vecIrq;
    end else begin
      // Nothing to vector to
      cause         = causeNone;
      vectorPcNextF = 32'h0000_0000;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pipelineClearTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineClearTracker (
  input  logic clk,
  input  logic arstN,
  input  logic pipelineClearF,
  input  logic irqAssert,
  input  logic fiqAssert,
  input  logic flushM,
  output logic pipelineClearD,
  output logic pipelineClearM
);

  // Token in E, only seen internally
  logic pipelineClearE;
  // Drain finished or an abort took over
  logic clearAll;

  // An assertion ends the drain
  // flushM means an abort killed it, the drain restarts later
  assign clearAll = irqAssert | fiqAssert | flushM;

  // Token follows the zero instruction one stage per cycle
  // stallD and flushE are ignored on purpose:
  //   the stall holds a bubble in D and the token is in that bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pipelineClearD <= 1'b0;
      pipelineClearE <= 1'b0;
      pipelineClearM <= 1'b0;
    end else if (clearAll) begin
      pipelineClearD <= 1'b0;
      pipelineClearE <= 1'b0;
      pipelineClearM <= 1'b0;
    end else begin
      pipelineClearD <= pipelineClearF;
      pipelineClearE <= pipelineClearD;
      pipelineClearM <= pipelineClearE;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exceptionLinkUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exceptionLinkUnit import excPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        exceptionSavePc,
  input  excCauseT    cause,
  input  pcSelT       pcInSelect,
  input  logic [31:0] pcD,
  input  logic        linkReady,
  output logic        linkValid,
  output logic [31:0] linkAddr,
  output procModeT    linkMode
);

  logic [31:0] linkOffset;
  procModeT    modeNext;
  logic        loadEntry;

  // Reset has nothing to bank
  assign loadEntry = exceptionSavePc && (cause != causeReset);

  // Offset from PCD chosen by the handler
  always_comb begin
    case (pcInSelect)
      pcSelPlus0: linkOffset = linkOffsetPlus0;
      pcSelPlus4: linkOffset = linkOffsetPlus4;
      default:    linkOffset = linkOffsetNormal;
    endcase
  end

  // Cause to banked mode
  always_comb begin
    case (cause)
      causeUndef:         modeNext = modeUnd;
      causeSwi:           modeNext = modeSvc;
      causePrefetchAbort: modeNext = modeAbt;
      causeDataAbort:     modeNext = modeAbt;
      causeIrq:           modeNext = modeIrq;
      causeFiq:           modeNext = modeFiq;
      // Reset and none never load
      default:            modeNext = modeSvc;
    endcase
  end

  // Valid rises on a save and drops once the register file takes it
  // A new save wins over a held entry, it owns the banked registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      linkValid <= 1'b0;
    end else if (loadEntry) begin
      linkValid <= 1'b1;
    end else if (linkReady) begin
      linkValid <= 1'b0;
    end
  end

  // Entry data, stable while valid is waiting
  always_ff @(posedge clk) begin
    if (loadEntry) begin
      linkAddr <= pcD + linkOffset;
      linkMode <= modeNext;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exceptionControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exceptionControl import excPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        undefinedInstrE,
  input  logic        swiE,
  input  logic        prefetchAbortE,
  input  logic        dataAbort,
  input  logic        irq,
  input  logic        fiq,
  input  logic        irqEnabled,
  input  logic        fiqEnabled,
  input  logic [31:0] pcD,
  input  logic        linkReady,
  output logic        flushD,
  output logic        flushE,
  output logic        flushM,
  output logic        flushW,
  output logic        stallD,
  output logic [31:0] vectorPcNextF,
  output logic        exceptionSavePc,
  output logic        resetMicrop,
  output logic        undefinedInstrM,
  output logic        swiM,
  output logic        prefetchAbortM,
  output logic        dataAbortCycle2,
  output logic        linkValid,
  output logic [31:0] linkAddr,
  output procModeT    linkMode
);

  // Drain token and interrupt handshake
  logic     pipelineClearF;
  logic     pipelineClearD;
  logic     pipelineClearM;
  logic     irqAssert;
  logic     fiqAssert;
  // Link entry controls
  pcSelT    pcInSelect;
  excCauseT cause;

  exceptionHandler exceptionHandler_inst (
    .clk(clk), .arstN(arstN),
    .undefinedInstrE(undefinedInstrE), .swiE(swiE), .prefetchAbortE(prefetchAbortE),
    .dataAbort(dataAbort), .irq(irq), .fiq(fiq),
    .irqEnabled(irqEnabled), .fiqEnabled(fiqEnabled),
    .pipelineClearD(pipelineClearD), .pipelineClearM(pipelineClearM),
    .undefinedInstrM(undefinedInstrM), .swiM(swiM), .prefetchAbortM(prefetchAbortM),
    .dataAbortCycle2(dataAbortCycle2), .irqAssert(irqAssert), .fiqAssert(fiqAssert),
    .pipelineClearF(pipelineClearF),
    .flushD(flushD), .flushE(flushE), .flushM(flushM), .flushW(flushW),
    .stallD(stallD), .resetMicrop(resetMicrop),
    .exceptionSavePc(exceptionSavePc), .pcInSelect(pcInSelect)
  );

  exceptionVectorAddress exceptionVectorAddress_inst (
    .arstN(arstN), .dataAbortCycle2(dataAbortCycle2),
    .fiqAssert(fiqAssert), .irqAssert(irqAssert),
    .prefetchAbortE(prefetchAbortE), .undefinedInstrE(undefinedInstrE), .swiE(swiE),
    .vectorPcNextF(vectorPcNextF), .cause(cause)
  );

  pipelineClearTracker pipelineClearTracker_inst (
    .clk(clk), .arstN(arstN), .pipelineClearF(pipelineClearF),
    .irqAssert(irqAssert), .fiqAssert(fiqAssert), .flushM(flushM),
    .pipelineClearD(pipelineClearD), .pipelineClearM(pipelineClearM)
  );

  exceptionLinkUnit exceptionLinkUnit_inst (
    .clk(clk), .arstN(arstN), .exceptionSavePc(exceptionSavePc),
    .cause(cause), .pcInSelect(pcInSelect), .pcD(pcD), .linkReady(linkReady),
    .linkValid(linkValid), .linkAddr(linkAddr), .linkMode(linkMode)
  );

endmodule

`default_nettype wire

// ==== testbench/tbExceptionControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbExceptionControl import excPkg::*; ();

  logic        clk;
  logic        arstN;
  logic        undefinedInstrE, swiE, prefetchAbortE, dataAbort;
  logic        irq, fiq, irqEnabled, fiqEnabled;
  logic [31:0] pcD;
  logic        linkReady;
  logic        flushD, flushE, flushM, flushW, stallD;
  logic [31:0] vectorPcNextF;
  logic        exceptionSavePc, resetMicrop;
  logic        undefinedInstrM, swiM, prefetchAbortM, dataAbortCycle2;
  logic        linkValid;
  logic [31:0] linkAddr;
  procModeT    linkMode;

  // One entry per stimulus line
  logic [7:0]  inQ[$];
  logic        chkQ[$];
  logic [10:0] flagQ[$];
  logic [31:0] vecQ[$];

  // Expected link entry under the valid/ready rule
  logic        expValid;
  logic [31:0] expAddr;
  procModeT    expMode;

  int cycleCount = 0;
  int cycleLimit = 1000;

  exceptionControl exceptionControl_inst (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Run limit set from the stimulus length
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Some tests failed");
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $fatal(1, "Simulation timed out");
    end
  end

  `include "include/tbCompare.svh"

  // Comment lines and other lines that do not parse are skipped
  task automatic loadStimulus();
    int          fd;
    int          fields;
    string       text;
    logic [7:0]  inBits;
    logic        chk;
    logic [10:0] flags;
    logic [31:0] vec;
    fd = $fopen("testbench/exceptionStimulus.txt", "r");
    if (fd == 0) begin
      $display("Some tests failed");
      $fatal(1, "The stimulus file could not be opened");
    end
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      fields = $sscanf(text, "%b %b %b %h", inBits, chk, flags, vec);
      if (fields == 4) begin
        inQ.push_back(inBits);
        chkQ.push_back(chk);
        flagQ.push_back(flags);
        vecQ.push_back(vec);
      end
    end
    $fclose(fd);
  endtask

  // Banked mode for the vector being taken
  // Both aborts go to abort mode
  function automatic procModeT modeForVector(input logic [31:0] vec);
    case (vec)
      vecUndef: return modeUnd;
      vecSwi:   return modeSvc;
      vecIrq:   return modeIrq;
      vecFiq:   return modeFiq;
      default:  return modeAbt;
    endcase
  endfunction

  initial begin
    int          idx;
    logic [10:0] flags;
    logic [31:0] vec;
    void'($urandom(70136));
    arstN = 1'b0;
    {undefinedInstrE, swiE, prefetchAbortE, dataAbort} = 4'b0000;
    {irq, fiq, irqEnabled, fiqEnabled} = 4'b0000;
    pcD = 32'h0;
    linkReady = 1'b0;
    expValid = 1'b0;
    expAddr = 32'h0;
    expMode = modeSvc;
    loadStimulus();
    cycleLimit = inQ.size() + 64;

    // Reset vector is fetched while reset is held
    repeat (8) begin
      @(negedge clk);
      #19;
      compareWord("vectorPcNextF", vectorPcNextF, vecReset);
      compareBit("exceptionSavePc", exceptionSavePc, 1'b1);
      compareBit("linkValid", linkValid, 1'b0);
    end

    for (idx = 0; idx < inQ.size(); idx++) begin
      @(negedge clk);
      arstN = 1'b1;
      {undefinedInstrE, swiE, prefetchAbortE, dataAbort,
       irq, fiq, irqEnabled, fiqEnabled} = inQ[idx];
      pcD = 32'h0000_8000 + 32'(idx * 4);
      // Mostly stalled so that entries wait and get replaced
      linkReady = ($urandom() % 3) == 0;
      flags = flagQ[idx];
      vec = vecQ[idx];
      // Sample just ahead of the rising edge
      #19;
      if (chkQ[idx]) begin
        compareBit("flushD", flushD, flags[10]);
        compareBit("flushE", flushE, flags[9]);
        compareBit("flushM", flushM, flags[8]);
        compareBit("flushW", flushW, flags[7]);
        compareBit("stallD", stallD, flags[6]);
        compareBit("resetMicrop", resetMicrop, flags[5]);
        compareBit("exceptionSavePc", exceptionSavePc, flags[4]);
        compareBit("undefinedInstrM", undefinedInstrM, flags[3]);
        compareBit("swiM", swiM, flags[2]);
        compareBit("prefetchAbortM", prefetchAbortM, flags[1]);
        compareBit("dataAbortCycle2", dataAbortCycle2, flags[0]);
        compareWord("vectorPcNextF", vectorPcNextF, vec);
      end
      compareBit("linkValid", linkValid, expValid);
      if (expValid) begin
        compareWord("linkAddr", linkAddr, expAddr);
        compareMode("linkMode", linkMode, expMode);
      end
      // Entry after this edge
      // A new save wins over a waiting one
      if (chkQ[idx] && flags[4]) begin
        expValid = 1'b1;
        expAddr = pcD + (((vec == vecIrq) || (vec == vecFiq)) ?
                         linkOffsetPlus4 : linkOffsetPlus0);
        expMode = modeForVector(vec);
      end else if (linkReady) begin
        expValid = 1'b0;
      end
    end

    @(negedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/excPkg.sv
verilog/exceptionHandler.sv
verilog/exceptionVectorAddress.sv
verilog/pipelineClearTracker.sv
verilog/exceptionLinkUnit.sv
verilog/exceptionControl.sv
testbench/tbExceptionControl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tbExceptionControl -f src.f -o simExceptionControl

# The simulator exits non-zero on $fatal, the log search below decides the result
./obj_dir/simExceptionControl > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// ==== testbench/exceptionStimulus.txt ====
// in: undefE swiE pabtE dabt irq fiq irqEn fiqEn, chk, flags, vectorPcNextF (hex)
// flags: flushD flushE flushM flushW stallD resetMicrop savePc undefM swiM pabtM dabtC2
00000000 1 00000000000 00000000
00010000 1 11111100000 00000000
00000000 1 10110010001 00000010
00000000 1 00000000000 00000000
11100000 1 10100010000 0000000C
11000000 1 10100011110 00000004
00000000 1 00000001100 00000000
00000010 1 00000000000 00000000
00001010 1 00000000000 00000000
00001010 1 01001000000 00000000
00001010 1 01001000000 00000000
00001010 1 10000010000 00000018
00000010 1 00000000000 00000000
00000011 1 00000000000 00000000
00001111 1 00000000000 00000000
00001111 1 01001000000 00000000
00001111 1 01001000000 00000000
00001111 1 10000010000 0000001C
00000000 1 00000000000 00000000
00001000 1 00000000000 00000000
00000100 1 00000000000 00000000
00001100 1 00000000000 00000000
00000010 1 00000000000 00000000
00001010 1 00000000000 00000000
00001010 1 01001000000 00000000
00011010 1 11111100000 00000000
00001010 1 10110010001 00000010
00001010 1 00000000000 00000000
00001010 1 01001000000 00000000
00001010 1 01001000000 00000000
00001010 1 10000010000 00000018
00000000 1 00000000000 00000000
01000000 1 10100010000 00000008
00100000 1 10100010100 0000000C
10000000 1 10100010010 00000004
00000000 1 00000001000 00000000
00000000 1 00000000000 00000000
